// ==== all.f ====
rtl/mouse_isa_pkg.sv
rtl/mouse_core_pkg.sv
rtl/mouse_exe_if.sv
rtl/mouse_alu.sv
rtl/mouse_pc_unit.sv
rtl/mouse_sequencer.sv
rtl/mouse_core.sv
testbench/mouse_bus_asserts.sv
testbench/mouse_tb.sv

// ==== testbench/mouse_tb.sv ====
// mouse core testbench: program, bus memory with stalls, reference model, checker
`timescale 1ns/1ns
`default_nettype none

module mouse_tb;

  typedef mouse_isa_pkg::word_t    word_t;
  typedef mouse_isa_pkg::reg_idx_t reg_idx_t;
  typedef mouse_isa_pkg::fn3_t     fn3_t;
  typedef mouse_isa_pkg::opcode_t  opcode_t;

  localparam int    clk_ns     = 4;
  localparam int    rst_cycles = 5;
  localparam word_t reset_pc   = mouse_core_pkg::default_reset_pc;
  localparam word_t gpr_base   = mouse_core_pkg::default_gpr_base;
  localparam word_t data_base  = 32'h8000_0100;  // 64 words for lw/sw

  typedef struct packed {
    word_t pc;      // expected fetch address
    logic  wr;      // write still due
    word_t wr_adr;
    word_t wr_dat;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        bus_vld;
  logic        bus_wen;
  word_t       bus_adr;
  word_t       bus_wdt;
  word_t       bus_rdt;
  logic        bus_rdy;

  word_t       mem [0:255];   // program, data and gpr window
  word_t       prog [0:63];
  int          plen = 0;
  logic        built = 1'b0;
  logic        done = 1'b0;
  logic [31:0] rng = 32'haef9_2049;
  int          low_run = 0;   // consecutive stall cycles

  // reference state
  word_t       ref_pc = reset_pc;
  word_t       ref_gpr [0:31];
  word_t       ref_dmem [0:63];
  expect_t     cur = '0;
  int          end_hits = 0;
  int          err_adr = 0;
  int          err_dat = 0;
  int          err_seq = 0;

  mouse_core u_dut (
    .clk     (clk),
    .rst     (rst),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt),
    .bus_rdy (bus_rdy)
  );

  //////////////////////////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, fn3_t f3,
                                  reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, mouse_isa_pkg::OP, 2'b11};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, fn3_t f3, reg_idx_t rd,
                                  opcode_t op);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, mouse_isa_pkg::SW, imm[4:0], mouse_isa_pkg::STORE, 2'b11};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1, fn3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], mouse_isa_pkg::BRANCH,
            2'b11};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t op);
    return {imm, rd, op, 2'b11};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, mouse_isa_pkg::JAL, 2'b11};
  endfunction

  task automatic append_insn(input word_t w);
    prog[plen] = w;
    plen++;
  endtask

  // not-taken branch, then a taken one over a word that must never run
  task automatic append_branch_pair(input fn3_t f3, input reg_idx_t n1, input reg_idx_t n2,
                                    input reg_idx_t t1, input reg_idx_t t2);
    append_insn(enc_b(13'd8, n2, n1, f3));
    append_insn(enc_b(13'd8, t2, t1, f3));
    append_insn(enc_i(12'h3e7, 0, mouse_isa_pkg::ADD, 20, mouse_isa_pkg::OP_IMM));
  endtask

  task automatic build_program();
    append_insn(enc_u(20'h80000, 1, mouse_isa_pkg::LUI));                  // x1 most negative
    append_insn(enc_i(12'hfff, 0, mouse_isa_pkg::ADD, 2, mouse_isa_pkg::OP_IMM));  // x2 = -1
    append_insn(enc_i(12'd5, 0, mouse_isa_pkg::ADD, 3, mouse_isa_pkg::OP_IMM));
    append_insn(enc_r(7'h00, 3, 2, mouse_isa_pkg::SLT, 4));
    append_insn(enc_r(7'h00, 3, 2, mouse_isa_pkg::SLTU, 5));
    append_insn(enc_r(7'h20, 2, 3, mouse_isa_pkg::ADD, 6));               // sub
    append_insn(enc_r(7'h00, 3, 2, mouse_isa_pkg::XOR, 7));
    append_insn(enc_r(7'h00, 3, 1, mouse_isa_pkg::OR, 8));
    append_insn(enc_r(7'h00, 1, 2, mouse_isa_pkg::AND, 9));
    append_insn(enc_i(12'd1, 1, mouse_isa_pkg::SLT, 10, mouse_isa_pkg::OP_IMM));
    append_insn(enc_i(12'hfff, 3, mouse_isa_pkg::SLTU, 11, mouse_isa_pkg::OP_IMM));
    append_insn(enc_i(12'hfff, 3, mouse_isa_pkg::XOR, 12, mouse_isa_pkg::OP_IMM));
    append_insn(enc_i(12'h7ff, 0, mouse_isa_pkg::OR, 13, mouse_isa_pkg::OP_IMM));
    append_insn(enc_i(12'h555, 2, mouse_isa_pkg::AND, 14, mouse_isa_pkg::OP_IMM));
    append_insn(enc_r(7'h00, 2, 1, mouse_isa_pkg::ADD, 15));              // wraps around
    append_insn(enc_u(20'h00001, 16, mouse_isa_pkg::AUIPC));
    append_insn(enc_i(12'h100, 1, mouse_isa_pkg::ADD, 17, mouse_isa_pkg::OP_IMM));  // data ptr
    append_insn(enc_s(12'd4, 6, 17));
    append_insn(enc_s(12'd8, 15, 17));
    append_insn(enc_i(12'd4, 17, mouse_isa_pkg::LW, 18, mouse_isa_pkg::LOAD));
    append_insn(enc_i(12'd8, 17, mouse_isa_pkg::LW, 19, mouse_isa_pkg::LOAD));
    append_insn(enc_r(7'h00, 3, 3, mouse_isa_pkg::ADD, 0));               // dropped write
    // x2 = -1, x3 = 5
    append_branch_pair(mouse_isa_pkg::BEQ, 2, 3, 3, 3);
    append_branch_pair(mouse_isa_pkg::BNE, 3, 3, 2, 3);
    append_branch_pair(mouse_isa_pkg::BLT, 3, 2, 2, 3);
    append_branch_pair(mouse_isa_pkg::BGE, 2, 3, 3, 2);
    append_branch_pair(mouse_isa_pkg::BLTU, 2, 3, 3, 2);
    append_branch_pair(mouse_isa_pkg::BGEU, 3, 2, 2, 3);
    append_insn(enc_j(21'd8, 21));
    append_insn(enc_i(12'h3e7, 0, mouse_isa_pkg::ADD, 20, mouse_isa_pkg::OP_IMM));
    append_insn(enc_u(20'h00000, 22, mouse_isa_pkg::AUIPC));
    append_insn(enc_i(12'd13, 22, 3'b000, 23, mouse_isa_pkg::JALR));    // odd target
    append_insn(enc_i(12'h3e7, 0, mouse_isa_pkg::ADD, 20, mouse_isa_pkg::OP_IMM));
    append_insn(enc_r(7'h00, 18, 0, mouse_isa_pkg::ADD, 24));             // x0 source
    append_insn(enc_j(21'd0, 0));                                         // park here
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic word_t alu_ref(fn3_t f3, word_t a, word_t b, logic sub);
    case (f3)
      mouse_isa_pkg::SLT:  return {31'd0, $signed(a) < $signed(b)};
      mouse_isa_pkg::SLTU: return {31'd0, a < b};
      mouse_isa_pkg::XOR:  return a ^ b;
      mouse_isa_pkg::OR:   return a | b;
      mouse_isa_pkg::AND:  return a & b;
      default:             return sub ? a - b : a + b;
    endcase
  endfunction

  function automatic logic taken(fn3_t f3, word_t a, word_t b);
    case (f3)
      mouse_isa_pkg::BEQ:  return a == b;
      mouse_isa_pkg::BNE:  return a != b;
      mouse_isa_pkg::BLT:  return $signed(a) < $signed(b);
      mouse_isa_pkg::BGE:  return $signed(a) >= $signed(b);
      mouse_isa_pkg::BLTU: return a < b;
      mouse_isa_pkg::BGEU: return a >= b;
      default:             return 1'b0;
    endcase
  endfunction

  function automatic logic [5:0] dmem_idx(word_t adr);
    word_t off;
    off = adr - data_base;
    return off[7:2];
  endfunction

  // one instruction on the shadow state
  function automatic expect_t ref_step();
    expect_t e;
    word_t   ins;
    word_t   a;
    word_t   b;
    word_t   r;
    word_t   nxt;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    logic    wr_rd;
    ins   = prog[(ref_pc - reset_pc) >> 2];
    a     = ref_gpr[ins[19:15]];
    b     = ref_gpr[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    e     = '0;
    e.pc  = ref_pc;
    r     = '0;
    wr_rd = 1'b1;
    nxt   = ref_pc + 4;
    case (ins[6:2])
      mouse_isa_pkg::LUI:    r = {ins[31:12], 12'h000};
      mouse_isa_pkg::AUIPC:  r = ref_pc + {ins[31:12], 12'h000};
      mouse_isa_pkg::JAL: begin
        r   = ref_pc + 4;
        nxt = ref_pc + imm_j;
      end
      mouse_isa_pkg::JALR: begin
        r   = ref_pc + 4;
        nxt = (a + imm_i) & ~32'd1;
      end
      mouse_isa_pkg::BRANCH: begin
        wr_rd = 1'b0;
        if (taken(ins[14:12], a, b)) begin
          nxt = ref_pc + imm_b;
        end
      end
      mouse_isa_pkg::LOAD:   r = ref_dmem[dmem_idx(a + imm_i)];
      mouse_isa_pkg::STORE: begin
        wr_rd    = 1'b0;
        e.wr     = 1'b1;
        e.wr_adr = a + imm_s;
        e.wr_dat = b;
        ref_dmem[dmem_idx(e.wr_adr)] = b;
      end
      mouse_isa_pkg::OP:     r = alu_ref(ins[14:12], a, b, ins[30]);
      mouse_isa_pkg::OP_IMM: r = alu_ref(ins[14:12], a, imm_i, 1'b0);
      default:               wr_rd = 1'b0;
    endcase
    if (wr_rd && ins[11:7] != 5'd0) begin  // x0 never written
      e.wr     = 1'b1;
      e.wr_adr = gpr_base + {ins[11:7], 2'b00};
      e.wr_dat = r;
      ref_gpr[ins[11:7]] = r;
    end
    ref_pc = nxt;
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      err_dat++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_adr(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      err_adr++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // fetches come from outside the gpr window and the data region
  function automatic logic is_fetch(word_t adr);
    return (adr[31:7] != gpr_base[31:7]) && (adr[31:8] != data_base[31:8]);
  endfunction

  always @(posedge clk) begin
    if (!rst && bus_vld && bus_rdy) begin
      if (bus_adr == gpr_base) begin
        err_seq++;
        $display("transfer at %0t ns goes to the x0 slot", $time);
      end
      if (bus_wen) begin
        if (!cur.wr) begin
          err_seq++;
          $display("unexpected write to %h during instruction at %h", bus_adr, cur.pc);
        end else begin
          check_adr($sformatf("write address, pc %h", cur.pc), cur.wr_adr, bus_adr);
          check_word($sformatf("write data, pc %h", cur.pc), cur.wr_dat, bus_wdt);
          cur.wr = 1'b0;
        end
      end else if (is_fetch(bus_adr)) begin
        if (cur.wr) begin
          err_seq++;
          $display("instruction at %h never wrote its result", cur.pc);
        end
        cur = ref_step();
        check_adr("fetch", cur.pc, bus_adr);
        if (cur.pc == reset_pc + 4 * (plen - 1)) begin  // parking jump
          end_hits++;
          done <= (end_hits == 2);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory model, random stalls
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] mem_idx(word_t adr);
    return {adr[21], adr[8:2]};  // gpr window in the upper half
  endfunction

  always @(posedge clk) begin
    rng = lcg_next(rng);
    if (low_run == 3 || rng[28]) begin  // at most three stalls in a row
      bus_rdy <= 1'b1;
      low_run <= 0;
    end else begin
      bus_rdy <= 1'b0;
      low_run <= low_run + 1;
    end
    if (!rst && bus_vld && bus_rdy) begin
      if (bus_wen) begin
        mem[mem_idx(bus_adr)] <= bus_wdt;
      end else begin
        bus_rdt <= mem[mem_idx(bus_adr)];  // held until the next read
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // clock, reset, run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(clk_ns / 2) clk = ~clk;
  end

  // every instruction fits in 5 phases of at most 4 cycles
  initial begin
    wait (built);
    #((((plen + 2) * 5 * 4) + rst_cycles + 4) * clk_ns);
    $display("watchdog expired before the program reached its final jump");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst     = 1'b1;
    bus_rdt = '0;
    bus_rdy = 1'b0;
    build_program();
    // nonzero fill, so a real read of the x0 slot shows up in results
    for (int i = 0; i < 256; i++) begin
      mem[i] = (i < plen) ? prog[i] : (32'hc0de_0000 | word_t'(i));
    end
    for (int i = 0; i < 32; i++) begin
      ref_gpr[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      ref_dmem[i] = '0;
    end
    built = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    repeat (4) @(posedge clk);
    $display("errors: address %0d, data %0d, sequence %0d, assertion %0d",
             err_adr, err_dat, err_seq, u_dut.u_bus_asserts.n_fail);
    if (err_adr + err_dat + err_seq + u_dut.u_bus_asserts.n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/mouse_bus_asserts.sv ====
// mouse bus checks: request hold under stall, idle after reset, no x0 write
`timescale 1ns/1ns
`default_nettype none

module mouse_bus_asserts #(
  parameter mouse_isa_pkg::word_t GPR_BASE = mouse_core_pkg::default_gpr_base
)(
  input logic                 clk,
  input logic                 rst,
  input logic                 bus_vld,
  input logic                 bus_wen,
  input mouse_isa_pkg::word_t bus_adr,
  input mouse_isa_pkg::word_t bus_wdt,
  input logic                 bus_rdy
);

  int unsigned n_fail = 0;  // failed assertion count

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // a stalled request stays up and unchanged
  property hold_under_stall;
    @(posedge clk) disable iff (rst)
      bus_vld && !bus_rdy |=> bus_vld && $stable(bus_wen) && $stable(bus_adr) &&
                              $stable(bus_wdt);
  endproperty

  a_hold: assert property (hold_under_stall) else begin
    n_fail++;
    $error("bus request changed while stalled");
  end

  // idle in reset and in the first cycle after it
  a_idle_rst: assert property (@(posedge clk) (rst || $fell(rst)) |-> !bus_vld) else begin
    n_fail++;
    $error("bus request during or right after reset");
  end

  // x0 slot is never written
  a_no_x0: assert property (@(posedge clk) disable iff (rst)
                            bus_vld && bus_wen |-> bus_adr != GPR_BASE) else begin
    n_fail++;
    $error("write to the x0 slot");
  end

endmodule

bind mouse_core mouse_bus_asserts #(
  .GPR_BASE (GPR_BASE)
) u_bus_asserts (
  .clk     (clk),
  .rst     (rst),
  .bus_vld (bus_vld),
  .bus_wen (bus_wen),
  .bus_adr (bus_adr),
  .bus_wdt (bus_wdt),
  .bus_rdy (bus_rdy)
);

`default_nettype wire

// ==== rtl/mouse_core.sv ====
// mouse core top: multi-cycle RV32I subset on one shared valid/ready bus
`timescale 1ns/1ns
`default_nettype none

module mouse_core #(
  parameter mouse_isa_pkg::word_t RESET_PC = mouse_core_pkg::default_reset_pc,
  parameter mouse_isa_pkg::word_t GPR_BASE = mouse_core_pkg::default_gpr_base
)(
  input  logic                 clk,
  input  logic                 rst,
  // shared bus, fetch, gpr and load/store
  output logic                 bus_vld,
  output logic                 bus_wen,
  output mouse_isa_pkg::word_t bus_adr,
  output mouse_isa_pkg::word_t bus_wdt,
  input  mouse_isa_pkg::word_t bus_rdt,
  input  logic                 bus_rdy
);

  mouse_exe_if exe ();  // operand/result bundle

  mouse_sequencer #(
    .GPR_BASE (GPR_BASE)
  ) u_seq (
    .clk     (clk),
    .rst     (rst),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt),
    .bus_rdy (bus_rdy),
    .exe     (exe.sequencer)
  );

  mouse_alu u_alu (
    .exe (exe.alu)
  );

  mouse_pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc (
    .clk (clk),
    .rst (rst),
    .exe (exe.pcu)
  );

endmodule

`default_nettype wire

// ==== rtl/mouse_sequencer.sv ====
// mouse sequencer: phase FSM, decoder, operand buffers and shared bus driver
`timescale 1ns/1ns
`default_nettype none

module mouse_sequencer #(
  parameter mouse_isa_pkg::word_t GPR_BASE = mouse_core_pkg::default_gpr_base
)(
  input  logic                 clk,
  input  logic                 rst,
  output logic                 bus_vld,
  output logic                 bus_wen,
  output mouse_isa_pkg::word_t bus_adr,
  output mouse_isa_pkg::word_t bus_wdt,
  input  mouse_isa_pkg::word_t bus_rdt,
  input  logic                 bus_rdy,
  mouse_exe_if.sequencer       exe
);

  // phase control
  mouse_core_pkg::phase_t   ph;       // phase register
  mouse_core_pkg::phase_t   pha;      // effective phase
  mouse_core_pkg::phase_t   nxt;
  mouse_core_pkg::phase_t   lst;      // phase that ended last
  logic                     vld_en;   // bus enabled after reset
  logic                     rdt_ok;   // last step was a real read
  logic                     act;      // phase needs a transfer
  logic                     step;     // phase ends this cycle
  logic                     last;     // final phase of the instruction

  // buffers and their bypass muxes
  mouse_isa_pkg::word_t     ins_buf;
  mouse_isa_pkg::word_t     buf_rs1;
  mouse_isa_pkg::word_t     buf_rs2;
  mouse_isa_pkg::word_t     ins;
  mouse_isa_pkg::word_t     dat;      // read data, zero for x0
  mouse_isa_pkg::word_t     rs1_val;
  mouse_isa_pkg::word_t     rs2_val;

  // decode
  mouse_isa_pkg::opcode_t   opc;
  mouse_isa_pkg::reg_idx_t  rd;
  mouse_isa_pkg::reg_idx_t  rs1;
  mouse_isa_pkg::reg_idx_t  rs2;
  mouse_isa_pkg::fn3_t      dec_fn3;
  mouse_isa_pkg::word_t     imi;
  mouse_isa_pkg::word_t     ims;
  mouse_isa_pkg::word_t     imb;
  mouse_isa_pkg::word_t     imu;
  mouse_isa_pkg::word_t     imj;

  // register n lives at GPR_BASE + 4n
  function automatic mouse_isa_pkg::word_t gpr_adr(mouse_isa_pkg::reg_idx_t idx);
    return {GPR_BASE[31:7], idx, 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // decoder
  ////////////////////////////////////////////////////////////////////////

  // right after fetch the instruction is still on the bus
  assign ins     = (lst == mouse_core_pkg::IF) ? bus_rdt : ins_buf;
  assign dat     = rdt_ok ? bus_rdt : '0;
  assign rs1_val = (lst == mouse_core_pkg::RS1) ? dat : buf_rs1;
  assign rs2_val = (lst == mouse_core_pkg::RS2) ? dat : buf_rs2;

  assign opc     = mouse_isa_pkg::opcode_t'(ins[6:2]);
  assign rd      = ins[11:7];
  assign rs1     = ins[19:15];
  assign rs2     = ins[24:20];
  assign dec_fn3 = ins[14:12];

  assign imi = {{21{ins[31]}}, ins[30:20]};
  assign ims = {{21{ins[31]}}, ins[30:25], ins[11:7]};
  assign imb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imu = {ins[31:12], 12'd0};
  assign imj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////////
  // phase FSM
  ////////////////////////////////////////////////////////////////////////

  // lui, auipc and jal skip the rs1 read
  always_comb begin
    pha = ph;
    if (ph == mouse_core_pkg::RS1 && (opc == mouse_isa_pkg::LUI ||
        opc == mouse_isa_pkg::AUIPC || opc == mouse_isa_pkg::JAL)) begin
      pha = mouse_core_pkg::WB;
    end
  end

  always_comb begin
    act = 1'b1;
    nxt = mouse_core_pkg::IF;  // after wb, mst, exe
    case (pha)
      mouse_core_pkg::IF:  nxt = mouse_core_pkg::RS1;
      mouse_core_pkg::RS1: begin
        act = (rs1 != '0);  // x0 read suppressed
        case (opc)
          mouse_isa_pkg::OP,
          mouse_isa_pkg::BRANCH,
          mouse_isa_pkg::STORE:  nxt = mouse_core_pkg::RS2;
          mouse_isa_pkg::LOAD:   nxt = mouse_core_pkg::MLD;
          mouse_isa_pkg::OP_IMM,
          mouse_isa_pkg::JALR:   nxt = mouse_core_pkg::WB;
          default:               nxt = mouse_core_pkg::EXE;  // unknown, retire as nop
        endcase
      end
      mouse_core_pkg::RS2: begin
        act = (rs2 != '0);
        case (opc)
          mouse_isa_pkg::BRANCH: nxt = mouse_core_pkg::EXE;
          mouse_isa_pkg::STORE:  nxt = mouse_core_pkg::MST;
          default:               nxt = mouse_core_pkg::WB;
        endcase
      end
      mouse_core_pkg::MLD: nxt = mouse_core_pkg::WB;
      mouse_core_pkg::EXE: act = 1'b0;  // one idle cycle
      mouse_core_pkg::WB:  act = (rd != '0);  // x0 write dropped
      default:             act = 1'b1;
    endcase
  end

  assign last    = (pha == mouse_core_pkg::WB) || (pha == mouse_core_pkg::MST) ||
                   (pha == mouse_core_pkg::EXE);
  assign bus_vld = vld_en & act;
  assign step    = act ? (bus_vld & bus_rdy) : 1'b1;
  assign exe.adv = step & last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ph     <= mouse_core_pkg::IF;
      lst    <= mouse_core_pkg::WB;
      rdt_ok <= 1'b0;
      vld_en <= 1'b0;
    end else begin
      vld_en <= 1'b1;
      if (step) begin
        ph     <= nxt;
        lst    <= pha;
        rdt_ok <= act & ~bus_wen;
      end
    end
  end

  // read data is held by memory until the next transfer, capture on step
  always_ff @(posedge clk) begin
    if (step) begin
      if (lst == mouse_core_pkg::IF)  ins_buf <= bus_rdt;
      if (lst == mouse_core_pkg::RS1) buf_rs1 <= dat;
      if (lst == mouse_core_pkg::RS2) buf_rs2 <= dat;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // operands to alu and pc unit
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    exe.opa  = rs1_val;
    exe.opb  = rs2_val;
    exe.fn3  = mouse_isa_pkg::ADD;  // plain add for addresses
    exe.alt  = 1'b0;
    exe.kind = mouse_core_pkg::STEP;
    exe.off  = imi;
    case (opc)
      mouse_isa_pkg::AUIPC: begin
        exe.opa = exe.pc;
        exe.opb = imu;
      end
      mouse_isa_pkg::JAL: begin
        exe.kind = mouse_core_pkg::JAL;
        exe.off  = imj;
      end
      mouse_isa_pkg::JALR:   exe.kind = mouse_core_pkg::JALR;
      mouse_isa_pkg::BRANCH: begin
        exe.fn3  = dec_fn3;  // branch condition
        exe.kind = mouse_core_pkg::BRANCH;
        exe.off  = imb;
      end
      mouse_isa_pkg::LOAD:   exe.opb = imi;
      mouse_isa_pkg::STORE:  exe.opb = ims;
      mouse_isa_pkg::OP_IMM: begin
        exe.opb = imi;
        exe.fn3 = dec_fn3;
      end
      mouse_isa_pkg::OP: begin
        exe.fn3 = dec_fn3;
        exe.alt = ins[30];  // funct7[5], sub
      end
      default: exe.alt = 1'b0;  // lui uses no operands
    endcase
  end

  ////////////////////////////////////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_wen = 1'b0;
    bus_adr = gpr_adr(rd);
    bus_wdt = '0;
    case (pha)
      mouse_core_pkg::IF:  bus_adr = exe.pc;
      mouse_core_pkg::RS1: bus_adr = gpr_adr(rs1);
      mouse_core_pkg::RS2: bus_adr = gpr_adr(rs2);
      mouse_core_pkg::MLD: bus_adr = exe.res;  // rs1 + imm
      mouse_core_pkg::MST: begin
        bus_wen = 1'b1;
        bus_adr = exe.res;
        bus_wdt = rs2_val;
      end
      mouse_core_pkg::WB: begin
        bus_wen = 1'b1;
        case (opc)
          mouse_isa_pkg::LUI:  bus_wdt = imu;
          mouse_isa_pkg::JAL,
          mouse_isa_pkg::JALR: bus_wdt = exe.lnk;
          mouse_isa_pkg::LOAD: bus_wdt = dat;
          default:             bus_wdt = exe.res;  // op, op-imm, auipc
        endcase
      end
      default: bus_wen = 1'b0;  // exe, bus idle
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mouse_pc_unit.sv ====
// mouse pc unit: program counter, branch decision, next pc and link value
`timescale 1ns/1ns
`default_nettype none

module mouse_pc_unit #(
  parameter mouse_isa_pkg::word_t RESET_PC = mouse_core_pkg::default_reset_pc
)(
  input  logic     clk,
  input  logic     rst,
  mouse_exe_if.pcu exe
);

  mouse_isa_pkg::word_t pc_r;    // pc register
  mouse_isa_pkg::word_t pc_inc;  // pc + 4
  mouse_isa_pkg::word_t pc_tgt;  // pc + offset
  mouse_isa_pkg::word_t jr_tgt;  // rs1 + offset
  mouse_isa_pkg::word_t pc_nxt;
  logic                 eq;
  logic                 lt;
  logic                 ltu;
  logic                 tkn;     // branch taken

  assign pc_inc = pc_r + 32'd4;
  assign pc_tgt = pc_r + exe.off;
  assign jr_tgt = exe.opa + exe.off;

  // branch compare, rs1 vs rs2
  assign eq  = (exe.opa == exe.opb);
  assign lt  = ($signed(exe.opa) < $signed(exe.opb));
  assign ltu = (exe.opa < exe.opb);

  always_comb begin
    case (exe.fn3)
      mouse_isa_pkg::BEQ:  tkn = eq;
      mouse_isa_pkg::BNE:  tkn = ~eq;
      mouse_isa_pkg::BLT:  tkn = lt;
      mouse_isa_pkg::BGE:  tkn = ~lt;
      mouse_isa_pkg::BLTU: tkn = ltu;
      mouse_isa_pkg::BGEU: tkn = ~ltu;
      default:             tkn = 1'b0;  // reserved codes fall through
    endcase
  end

  always_comb begin
    case (exe.kind)
      mouse_core_pkg::JAL:    pc_nxt = pc_tgt;
      mouse_core_pkg::JALR:   pc_nxt = {jr_tgt[31:1], 1'b0};
      mouse_core_pkg::BRANCH: pc_nxt = tkn ? pc_tgt : pc_inc;
      default:                pc_nxt = pc_inc;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_r <= RESET_PC;
    end else if (exe.adv) begin  // instruction retires
      pc_r <= pc_nxt;
    end
  end

  assign exe.pc  = pc_r;
  assign exe.lnk = pc_inc;

endmodule

`default_nettype wire

// ==== rtl/mouse_alu.sv ====
// mouse alu: shared 33-bit adder for add/sub/compare/address plus logic ops
`timescale 1ns/1ns
`default_nettype none

module mouse_alu (
  mouse_exe_if.alu exe
);

  localparam int unsigned xlen = mouse_isa_pkg::xlen;

  logic                 sub;      // subtract, also for compares
  logic                 uns;      // zero extension for sltu
  logic [xlen:0]        add_a;
  logic [xlen:0]        add_b;
  logic [xlen:0]        add_sum;  // bit xlen carries the sign
  mouse_isa_pkg::word_t log_val;

  //////////////////////////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////////////////////////

  assign uns = (exe.fn3 == mouse_isa_pkg::SLTU);
  assign sub = exe.alt | uns | (exe.fn3 == mouse_isa_pkg::SLT);

  assign add_a   = {exe.opa[xlen-1] & ~uns, exe.opa};  // sign or zero ext
  assign add_b   = {exe.opb[xlen-1] & ~uns, exe.opb} ^ {(xlen+1){sub}};
  assign add_sum = add_a + add_b + (xlen+1)'(sub);     // two's complement when sub

  // logic unit
  always_comb begin
    case (exe.fn3)
      mouse_isa_pkg::XOR: log_val = exe.opa ^ exe.opb;
      mouse_isa_pkg::OR:  log_val = exe.opa | exe.opb;
      default:            log_val = exe.opa & exe.opb;
    endcase
  end

  // result select
  always_comb begin
    case (exe.fn3)
      mouse_isa_pkg::SLT,
      mouse_isa_pkg::SLTU: exe.res = mouse_isa_pkg::word_t'(add_sum[xlen]);  // borrow/sign
      mouse_isa_pkg::XOR,
      mouse_isa_pkg::OR,
      mouse_isa_pkg::AND:  exe.res = log_val;
      default:             exe.res = add_sum[xlen-1:0];  // add, sub, addresses
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mouse_exe_if.sv ====
// operand and result bundle between the sequencer, the alu and the pc unit
`timescale 1ns/1ns
`default_nettype none

interface mouse_exe_if;

  // operands from the sequencer
  mouse_isa_pkg::word_t     opa;   // rs1 or pc
  mouse_isa_pkg::word_t     opb;   // rs2 or immediate
  mouse_isa_pkg::fn3_t      fn3;   // alu op or branch condition
  logic                     alt;   // sub request
  mouse_core_pkg::pc_kind_t kind;  // next pc selection
  mouse_isa_pkg::word_t     off;   // jump/branch offset
  logic                     adv;   // retire strobe

  // results
  mouse_isa_pkg::word_t     res;   // alu result
  mouse_isa_pkg::word_t     pc;    // current pc
  mouse_isa_pkg::word_t     lnk;   // pc + 4

  modport sequencer (output opa, opb, fn3, alt, kind, off, adv,
                     input  res, pc, lnk);

  modport alu (input  opa, opb, fn3, alt,
               output res);

  // pc unit side
  modport pcu (input  opa, opb, fn3, kind, off, adv,
               output pc, lnk);

endinterface

`default_nettype wire

// ==== rtl/mouse_core_pkg.sv ====
// mouse core microarchitecture: phase encoding, pc update kinds, default map
`default_nettype none

package mouse_core_pkg;

  // instruction phases, gpr access phases share bit 2
  typedef enum logic [2:0] {
    IF  = 3'b000,  // instruction fetch
    MLD = 3'b001,  // memory load
    MST = 3'b010,  // memory store
    EXE = 3'b011,  // branch decision, bus idle
    WB  = 3'b100,  // gpr write-back
    RS1 = 3'b101,  // gpr rs1 read
    RS2 = 3'b110   // gpr rs2 read
  } phase_t;

  // how the pc moves at the end of an instruction
  typedef enum logic [1:0] {
    STEP   = 2'd0,  // pc + 4
    JAL    = 2'd1,  // pc + imm
    JALR   = 2'd2,  // rs1 + imm, lsb cleared
    BRANCH = 2'd3   // pc + imm if taken
  } pc_kind_t;

  // default memory map
  localparam mouse_isa_pkg::word_t default_reset_pc = 32'h8000_0000;
  localparam mouse_isa_pkg::word_t default_gpr_base = 32'h803f_ff80;  // x[n] at base + 4n

endpackage

`default_nettype wire

// ==== rtl/mouse_isa_pkg.sv ====
// RV32I subset definitions: word types, major opcodes and funct3 codes
`default_nettype none

package mouse_isa_pkg;

  localparam int unsigned xlen = 32;  // word width

  typedef logic [xlen-1:0] word_t;     // data or address word
  typedef logic [4:0]      reg_idx_t;  // gpr index
  typedef logic [2:0]      fn3_t;      // funct3 field

  //////////////////////////////////////////////////////////////////////
  // major opcodes, instruction bits [6:2]
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,
    OP_IMM = 5'b00_100,
    AUIPC  = 5'b00_101,
    STORE  = 5'b01_000,
    OP     = 5'b01_100,
    LUI    = 5'b01_101,
    BRANCH = 5'b11_000,
    JALR   = 5'b11_001,
    JAL    = 5'b11_011
  } opcode_t;

  // alu funct3, R and I type
  localparam fn3_t ADD  = 3'b000;  // funct7[5] selects sub
  localparam fn3_t SLT  = 3'b010;
  localparam fn3_t SLTU = 3'b011;
  localparam fn3_t XOR  = 3'b100;
  localparam fn3_t OR   = 3'b110;
  localparam fn3_t AND  = 3'b111;

  // branch conditions
  localparam fn3_t BEQ  = 3'b000;
  localparam fn3_t BNE  = 3'b001;
  localparam fn3_t BLT  = 3'b100;  // signed
  localparam fn3_t BGE  = 3'b101;  // signed
  localparam fn3_t BLTU = 3'b110;
  localparam fn3_t BGEU = 3'b111;

  // word access only
  localparam fn3_t LW   = 3'b010;
  localparam fn3_t SW   = 3'b010;

endpackage

`default_nettype wire
